//--- hdl/axis_pkg.sv
/*
 * Shared widths, depths and the beat type of the packet stream buffer.
 * Every design file imports this package with a wildcard import.
 */

package axis_pkg;

   // ------------------------------------------------------------------
   // stream geometry
   // ------------------------------------------------------------------
   localparam int DATA_BYTES = 4;

   // one beat as it travels through the design, 37 bits
   typedef struct packed {
      logic                       last;
      logic [DATA_BYTES-1:0]      keep;
      logic [DATA_BYTES-1:0][7:0] data;
   } BEAT_T;

   // ------------------------------------------------------------------
   // buffering
   // ------------------------------------------------------------------
   localparam int FIFO_DEPTH    = 64;
   localparam int MAX_PKT_BEATS = 16;

   // staging slot length and beat index widths
   localparam int LEN_WIDTH = $clog2(MAX_PKT_BEATS + 1);
   localparam int IDX_WIDTH = $clog2(MAX_PKT_BEATS);

   // fill count and tlast counters must reach FIFO_DEPTH
   localparam int CNT_WIDTH = $clog2(FIFO_DEPTH + 1);

   localparam int STAT_WIDTH = 16;

endpackage

//--- hdl/axis_if.sv
/*
 * Byte-lane stream carrying one beat per transfer with valid/ready.
 * The source drives valid and beat, the sink drives ready, and the
 * monitor view only observes.
 */

`timescale 1ns/1ns

interface axis_if
   import axis_pkg::*;
();

   logic  valid;
   logic  ready;
   BEAT_T beat;

   modport source (
      output valid,
      output beat,
      input  ready
   );

   modport sink (
      input  valid,
      input  beat,
      output ready
   );

   // passive view for counters and probes
   modport monitor (
      input valid,
      input ready,
      input beat
   );

endinterface

//--- hdl/fifo_sync.sv
/*
 * Synchronous first-word-fall-through FIFO with a typed entry.
 * The head entry is always on rd_data while empty is low, and rd pops it.
 * Writes while full and reads while empty are ignored.
 */

`timescale 1ns/1ns

module fifo_sync
   import axis_pkg::*;
#(
   parameter type DATA_T = logic [7:0],
   parameter int  DEPTH  = 16
) (
   input  logic                 axi4s_out,
   input  logic                 rst,

   input  logic                 wr,
   input  DATA_T                wr_data,
   output logic                 full,

   input  logic                 rd,
   output DATA_T                rd_data,
   output logic                 empty,

   output logic [CNT_WIDTH-1:0] count
);

   DATA_T                    mem [DEPTH];
   logic [$clog2(DEPTH)-1:0] wr_ptr;
   logic [$clog2(DEPTH)-1:0] rd_ptr;
   logic                     do_wr;
   logic                     do_rd;

   // pointer increment with wrap at an arbitrary depth
   function automatic logic [$clog2(DEPTH)-1:0] next_ptr(
      input logic [$clog2(DEPTH)-1:0] ptr
   );
      if (int'(ptr) == DEPTH - 1) begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   assign do_wr = wr && !full;
   assign do_rd = rd && !empty;

   assign full  = (count == CNT_WIDTH'(DEPTH));
   assign empty = (count == '0);

   // head of queue falls through to the read side
   assign rd_data = mem[rd_ptr];

   always_ff @(posedge axi4s_out) begin
      if (do_wr) begin
         mem[wr_ptr] <= wr_data;
      end
   end

   always_ff @(posedge axi4s_out) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (do_rd) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

//--- hdl/pkt_discard_ovfl.sv
/*
 * Packet staging for an ingress stream that ignores back-pressure.
 * Each packet lands in one of two slots and is forwarded whole on staged.
 * Packets arriving with both slots busy, or longer than MAX_PKT_BEATS,
 * are dropped and reported by a one-cycle drop pulse.
 */

`timescale 1ns/1ns

module pkt_discard_ovfl
   import axis_pkg::*;
(
   input  logic   axi4s_out,
   input  logic   rst,

   axis_if.sink   ingress,
   axis_if.source staged,

   output logic   drop
);

   typedef enum logic [1:0] {
      S_FREE,
      S_FILLING,
      S_READY,
      S_FORWARDING
   } slot_state_t;

   BEAT_T                slot_mem   [2][MAX_PKT_BEATS];
   slot_state_t          slot_state [2];
   logic [LEN_WIDTH-1:0] slot_len   [2];

   // wr_sel is the slot the next kept packet goes to, rd_sel the oldest one
   logic                 wr_sel;
   logic                 rd_sel;

   logic                 in_pkt;
   logic                 in_lost;
   logic                 drop_pend;

   logic                 sop;
   logic                 take_first;
   logic                 take_next;
   logic                 too_long;
   logic                 no_slot;
   logic                 lost_end;
   logic                 wr_en;
   logic [IDX_WIDTH-1:0] wr_idx;

   logic [LEN_WIDTH-1:0] rd_idx;
   logic                 fwd_xfer;
   logic                 fwd_end;

   // ingress never stalls
   assign ingress.ready = 1'b1;

   // ------------------------------------------------------------------
   // ingress classification
   // ------------------------------------------------------------------
   assign sop        = !in_pkt;
   assign take_first = ingress.valid && sop && (slot_state[wr_sel] == S_FREE);
   assign no_slot    = ingress.valid && sop && (slot_state[wr_sel] != S_FREE);
   assign take_next  = ingress.valid && !sop && !in_lost &&
                       (slot_len[wr_sel] != LEN_WIDTH'(MAX_PKT_BEATS));
   assign too_long   = ingress.valid && !sop && !in_lost &&
                       (slot_len[wr_sel] == LEN_WIDTH'(MAX_PKT_BEATS));
   assign lost_end   = ingress.valid && !sop && in_lost && ingress.beat.last;

   assign wr_en  = take_first || take_next;
   assign wr_idx = take_first ? '0 : slot_len[wr_sel][IDX_WIDTH-1:0];

   always_ff @(posedge axi4s_out) begin
      if (wr_en) begin
         slot_mem[wr_sel][wr_idx] <= ingress.beat;
      end
   end

   // ------------------------------------------------------------------
   // forwarding side, oldest slot first
   // ------------------------------------------------------------------
   assign staged.valid = (slot_state[rd_sel] == S_READY) ||
                         (slot_state[rd_sel] == S_FORWARDING);
   assign staged.beat  = slot_mem[rd_sel][rd_idx[IDX_WIDTH-1:0]];

   assign fwd_xfer = staged.valid && staged.ready;
   assign fwd_end  = fwd_xfer && (rd_idx + 1'b1 == slot_len[rd_sel]);

   always_ff @(posedge axi4s_out) begin
      if (rst) begin
         slot_state <= '{default: S_FREE};
         slot_len   <= '{default: '0};
         wr_sel     <= 1'b0;
         rd_sel     <= 1'b0;
         in_pkt     <= 1'b0;
         in_lost    <= 1'b0;
         drop_pend  <= 1'b0;
         drop       <= 1'b0;
         rd_idx     <= '0;
      end else begin
         drop <= 1'b0;

         if (ingress.valid) begin
            in_pkt <= !ingress.beat.last;
         end

         if (take_first) begin
            in_lost          <= 1'b0;
            slot_len[wr_sel] <= LEN_WIDTH'(1);
            if (ingress.beat.last) begin
               slot_state[wr_sel] <= S_READY;
               wr_sel             <= !wr_sel;
            end else begin
               slot_state[wr_sel] <= S_FILLING;
            end
         end

         if (take_next) begin
            slot_len[wr_sel] <= slot_len[wr_sel] + 1'b1;
            if (ingress.beat.last) begin
               slot_state[wr_sel] <= S_READY;
               wr_sel             <= !wr_sel;
            end
         end

         // oversized packet gives its slot back at once
         if (too_long) begin
            slot_state[wr_sel] <= S_FREE;
            in_lost            <= 1'b1;
            drop_pend          <= 1'b0;
            drop               <= 1'b1;
         end

         // both slots busy, count the loss when the packet ends
         if (no_slot) begin
            in_lost   <= 1'b1;
            drop_pend <= 1'b1;
            drop      <= ingress.beat.last;
         end

         if (lost_end) begin
            drop <= drop_pend;
         end

         if (fwd_xfer) begin
            if (fwd_end) begin
               slot_state[rd_sel] <= S_FREE;
               rd_sel             <= !rd_sel;
               rd_idx             <= '0;
            end else begin
               slot_state[rd_sel] <= S_FORWARDING;
               rd_idx             <= rd_idx + 1'b1;
            end
         end
      end
   end

endmodule

//--- hdl/pkt_fifo_sync.sv
/*
 * Packet FIFO between the staging block and the egress stream.
 * With STR_FWD_MODE set, egress valid waits until a whole packet is stored,
 * so a packet leaves without gaps. With it clear the FIFO is cut-through.
 */

`timescale 1ns/1ns

module pkt_fifo_sync
   import axis_pkg::*;
#(
   parameter bit STR_FWD_MODE = 1'b1
) (
   input  logic   axi4s_out,
   input  logic   rst,

   axis_if.sink   staged,
   axis_if.source egress
);

   logic  wr;
   logic  rd;
   logic  full;
   logic  fifo_empty;
   BEAT_T rd_data;
   logic  pkt_avail;

   // ------------------------------------------------------------------
   // FIFO write and read strobes
   // ------------------------------------------------------------------
   assign staged.ready = !full;
   assign wr           = staged.valid && staged.ready;
   assign rd           = egress.valid && egress.ready;

   // fill level is not needed here
   fifo_sync #(
      .DATA_T (BEAT_T),
      .DEPTH  (FIFO_DEPTH)
   ) fifo_inst (
      .axi4s_out (axi4s_out),
      .rst       (rst),
      .wr        (wr),
      .wr_data   (staged.beat),
      .full      (full),
      .rd        (rd),
      .rd_data   (rd_data),
      .empty     (fifo_empty),
      .count     ()
   );

   // ------------------------------------------------------------------
   // store-and-forward gating
   // ------------------------------------------------------------------
   generate
      if (STR_FWD_MODE) begin : g_str_fwd
         logic [CNT_WIDTH-1:0] wr_last_cnt;
         logic [CNT_WIDTH-1:0] rd_last_cnt;

         always_ff @(posedge axi4s_out) begin
            if (rst) begin
               wr_last_cnt <= '0;
            end else if (wr && staged.beat.last) begin
               wr_last_cnt <= wr_last_cnt + 1'b1;
            end
         end

         always_ff @(posedge axi4s_out) begin
            if (rst) begin
               rd_last_cnt <= '0;
            end else if (rd && rd_data.last) begin
               rd_last_cnt <= rd_last_cnt + 1'b1;
            end
         end

         // the counters wrap together, at most FIFO_DEPTH packets apart
         assign pkt_avail = (wr_last_cnt != rd_last_cnt);
      end else begin : g_cut_thru
         assign pkt_avail = 1'b1;
      end
   endgenerate

   assign egress.valid = !fifo_empty && pkt_avail;
   assign egress.beat  = rd_data;

endmodule

//--- hdl/pkt_stats.sv
/*
 * Packet statistics. Counts packets delivered on egress and packets
 * dropped at staging. Both counters stick at their maximum.
 */

`timescale 1ns/1ns

module pkt_stats
   import axis_pkg::*;
(
   input  logic                  axi4s_out,
   input  logic                  rst,

   axis_if.monitor               egress,
   input  logic                  drop,

   output logic [STAT_WIDTH-1:0] pkt_count,
   output logic [STAT_WIDTH-1:0] drop_count
);

   logic pkt_done;

   // a packet counts once its last beat has left
   assign pkt_done = egress.valid && egress.ready && egress.beat.last;

   always_ff @(posedge axi4s_out) begin
      if (rst) begin
         pkt_count  <= '0;
         drop_count <= '0;
      end else begin
         if (pkt_done && (pkt_count != '1)) begin
            pkt_count <= pkt_count + 1'b1;
         end
         if (drop && (drop_count != '1)) begin
            drop_count <= drop_count + 1'b1;
         end
      end
   end

endmodule

//--- hdl/pkt_buffer_top.sv
/*
 * Top level of the packet stream buffer. Maps the plain stream ports onto
 * stream interfaces and chains staging, packet FIFO and statistics.
 */

`timescale 1ns/1ns

module pkt_buffer_top
   import axis_pkg::*;
(
   input  logic                    axi4s_out,
   input  logic                    rst,

   input  logic                    ingress_valid,
   input  logic [8*DATA_BYTES-1:0] ingress_data,
   input  logic [DATA_BYTES-1:0]   ingress_keep,
   input  logic                    ingress_last,

   output logic                    egress_valid,
   input  logic                    egress_ready,
   output logic [8*DATA_BYTES-1:0] egress_data,
   output logic [DATA_BYTES-1:0]   egress_keep,
   output logic                    egress_last,

   output logic [STAT_WIDTH-1:0]   pkt_count,
   output logic [STAT_WIDTH-1:0]   drop_count
);

   axis_if ingress ();
   axis_if staged ();
   axis_if egress ();

   logic drop;

   // ------------------------------------------------------------------
   // port mapping
   // ------------------------------------------------------------------
   assign ingress.valid = ingress_valid;
   assign ingress.beat  = '{last: ingress_last, keep: ingress_keep, data: ingress_data};

   assign egress.ready  = egress_ready;
   assign egress_valid  = egress.valid;
   assign egress_data   = egress.beat.data;
   assign egress_keep   = egress.beat.keep;
   assign egress_last   = egress.beat.last;

   // ------------------------------------------------------------------
   // datapath
   // ------------------------------------------------------------------
   pkt_discard_ovfl discard_inst (
      .axi4s_out (axi4s_out),
      .rst       (rst),
      .ingress   (ingress),
      .staged    (staged),
      .drop      (drop)
   );

   pkt_fifo_sync #(
      .STR_FWD_MODE (1'b1)
   ) pkt_fifo_inst (
      .axi4s_out (axi4s_out),
      .rst       (rst),
      .staged    (staged),
      .egress    (egress)
   );

   pkt_stats stats_inst (
      .axi4s_out  (axi4s_out),
      .rst        (rst),
      .egress     (egress),
      .drop       (drop),
      .pkt_count  (pkt_count),
      .drop_count (drop_count)
   );

endmodule

//--- test/tb_pkt_buffer.sv
/*
 * Testbench for the packet stream buffer. Sends spaced random packets,
 * some of them oversized, then a back-to-back burst against a stalled
 * egress, and checks every egress packet against a reference queue.
 */

`timescale 1ns/1ns

module tb_pkt_buffer
   import axis_pkg::*;
();

   localparam int N_SPACED = 15;
   localparam int N_BURST  = 14;
   localparam int IDLE_GAP = MAX_PKT_BEATS + 4;

   logic                    axi4s_out;
   logic                    rst;
   logic                    ingress_valid;
   logic [8*DATA_BYTES-1:0] ingress_data;
   logic [DATA_BYTES-1:0]   ingress_keep;
   logic                    ingress_last;
   logic                    egress_valid;
   logic                    egress_ready;
   logic [8*DATA_BYTES-1:0] egress_data;
   logic [DATA_BYTES-1:0]   egress_keep;
   logic                    egress_last;
   logic [STAT_WIDTH-1:0]   pkt_count;
   logic [STAT_WIDTH-1:0]   drop_count;

   // reference packets, beats of all packets stored back to back
   BEAT_T ref_beats [$];
   int    ref_start [$];
   int    ref_len   [$];
   bit    ref_big   [$];

   BEAT_T rx_beats [$];
   int    n_done;      // packets whose last beat has been driven
   // packets fully sent when the current egress packet began
   int    first_done;
   int    ref_idx;
   int    rx_pkts;
   bit    allow_skip;
   int    cycle_count;
   int    cycle_limit = 2000;

   pkt_buffer_top pkt_buffer_top_inst (
      .axi4s_out     (axi4s_out),
      .rst           (rst),
      .ingress_valid (ingress_valid),
      .ingress_data  (ingress_data),
      .ingress_keep  (ingress_keep),
      .ingress_last  (ingress_last),
      .egress_valid  (egress_valid),
      .egress_ready  (egress_ready),
      .egress_data   (egress_data),
      .egress_keep   (egress_keep),
      .egress_last   (egress_last),
      .pkt_count     (pkt_count),
      .drop_count    (drop_count)
   );

   initial begin
      axi4s_out = 1'b0;
      forever #20 axi4s_out = ~axi4s_out;
   end

   // ------------------------------------------------------------------
   // helpers
   // ------------------------------------------------------------------
   task automatic report_error(input string msg);
      $display("** Error at %0t ns: %s", $time, msg);
      $display("TEST FAILED");
      $fatal(1, "stopped at the first error");
   endtask

   function automatic void add_packet(input int len);
      BEAT_T b;
      ref_start.push_back(ref_beats.size());
      ref_len.push_back(len);
      ref_big.push_back(len > MAX_PKT_BEATS);
      for (int i = 0; i < len; i++) begin
         b.data = $urandom;
         b.keep = DATA_BYTES'($urandom);
         b.last = (i == len - 1);
         ref_beats.push_back(b);
      end
   endfunction

   task automatic drive_packet(input int p);
      BEAT_T b;
      for (int i = 0; i < ref_len[p]; i++) begin
         b = ref_beats[ref_start[p] + i];
         @(negedge axi4s_out);
         ingress_valid = 1'b1;
         ingress_data  = b.data;
         ingress_keep  = b.keep;
         ingress_last  = b.last;
      end
      n_done++;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(negedge axi4s_out);
         ingress_valid = 1'b0;
         ingress_last  = 1'b0;
      end
   endtask

   function automatic bit packet_matches(input int p);
      if (ref_len[p] != rx_beats.size()) begin
         return 1'b0;
      end
      for (int i = 0; i < ref_len[p]; i++) begin
         if (rx_beats[i] != ref_beats[ref_start[p] + i]) begin
            return 1'b0;
         end
      end
      return 1'b1;
   endfunction

   task automatic check_packet();
      assert (rx_beats.size() <= MAX_PKT_BEATS)
         else report_error($sformatf("egress packet of %0d beats is oversized",
                                     rx_beats.size()));
      // oversized packets never show up, overflow may also skip kept ones
      // only packets complete at ingress before the first egress beat qualify
      while (ref_idx < first_done &&
             (ref_big[ref_idx] || (allow_skip && !packet_matches(ref_idx)))) begin
         ref_idx++;
      end
      assert (ref_idx < first_done && packet_matches(ref_idx))
         else report_error($sformatf("egress packet %0d matches no sent packet in order",
                                     rx_pkts));
      ref_idx++;
      rx_pkts++;
      rx_beats.delete();
   endtask

   // ------------------------------------------------------------------
   // egress monitor and protocol checks
   // ------------------------------------------------------------------
   always @(posedge axi4s_out) begin : monitor
      BEAT_T b;
      if (!rst && egress_valid && egress_ready) begin
         if (rx_beats.size() == 0) begin
            first_done = n_done;
         end
         b.data = egress_data;
         b.keep = egress_keep;
         b.last = egress_last;
         rx_beats.push_back(b);
         if (egress_last) begin
            check_packet();
         end
      end
   end

   // store-and-forward leaves no gap inside a packet
   assert property (@(posedge axi4s_out) disable iff (rst)
      egress_valid && !(egress_ready && egress_last) |=> egress_valid)
      else report_error("egress_valid fell inside a packet");

   assert property (@(posedge axi4s_out) disable iff (rst)
      egress_valid && !egress_ready |=> $stable({egress_data, egress_keep, egress_last}))
      else report_error("egress beat changed while stalled");

   always @(posedge axi4s_out) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count > cycle_limit) begin
         $display("timeout: the run did not finish within %0d cycles", cycle_limit);
         $display("TEST FAILED");
         $fatal(1, "timeout");
      end
   end

   // ------------------------------------------------------------------
   // stimulus
   // ------------------------------------------------------------------
   initial begin
      int n_legal;
      int n_big;
      void'($urandom(32'h639a));
      rst           = 1'b1;
      ingress_valid = 1'b0;
      ingress_data  = '0;
      ingress_keep  = '0;
      ingress_last  = 1'b0;
      egress_ready  = 1'b1;
      n_done        = 0;
      first_done    = 0;
      ref_idx       = 0;
      rx_pkts       = 0;
      allow_skip    = 1'b0;
      n_legal       = 0;
      n_big         = 0;

      // spaced packets with an oversized one now and then, then the burst
      for (int i = 0; i < N_SPACED; i++) begin
         if (i % 5 == 3) begin
            add_packet($urandom_range(MAX_PKT_BEATS + 8, MAX_PKT_BEATS + 1));
            n_big++;
         end else begin
            add_packet($urandom_range(MAX_PKT_BEATS, 1));
            n_legal++;
         end
      end
      for (int i = 0; i < N_BURST; i++) begin
         add_packet($urandom_range(MAX_PKT_BEATS, 8));
      end
      cycle_limit = ref_beats.size() * 4 + 2000;

      repeat (3) @(posedge axi4s_out);
      @(negedge axi4s_out);
      rst = 1'b0;
      assert (!egress_valid && pkt_count == '0 && drop_count == '0)
         else report_error("outputs not idle after reset");

      for (int p = 0; p < N_SPACED; p++) begin
         drive_packet(p);
         idle_cycles(IDLE_GAP);
      end
      while (rx_pkts != n_legal) begin
         @(posedge axi4s_out);
      end
      idle_cycles(4);
      assert (int'(pkt_count) == n_legal)
         else report_error($sformatf("pkt_count %0d, expected %0d", pkt_count, n_legal));
      assert (int'(drop_count) == n_big)
         else report_error($sformatf("drop_count %0d, expected %0d", drop_count, n_big));

      // overflow burst against a stalled egress
      allow_skip   = 1'b1;
      egress_ready = 1'b0;
      for (int p = N_SPACED; p < N_SPACED + N_BURST; p++) begin
         drive_packet(p);
      end
      idle_cycles(IDLE_GAP);
      while (int'(pkt_count) + int'(drop_count) != N_SPACED + N_BURST) begin
         @(negedge axi4s_out);
         egress_ready = ($urandom_range(3, 0) != 0);
      end
      egress_ready = 1'b1;
      idle_cycles(4);
      assert (int'(drop_count) > n_big)
         else report_error("no packet dropped during the overflow burst");
      assert (rx_pkts == int'(pkt_count))
         else report_error($sformatf("%0d packets seen, pkt_count %0d", rx_pkts, pkt_count));
      assert (!egress_valid)
         else report_error("egress_valid still high after the last packet");

      $display("TEST OK");
      $finish;
   end

endmodule

//--- filelist.f
hdl/axis_pkg.sv
hdl/axis_if.sv
hdl/fifo_sync.sv
hdl/pkt_discard_ovfl.sv
hdl/pkt_fifo_sync.sv
hdl/pkt_stats.sv
hdl/pkt_buffer_top.sv
test/tb_pkt_buffer.sv

//--- Makefile
# Verilator simulation of the packet stream buffer

VERILATOR ?= verilator
TOP       ?= tb_pkt_buffer
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= TEST OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
